//--- cpuPkg.sv
package cpuPkg;

	// basic widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  shamt_t;

	typedef enum logic [3:0]
	{
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} aluOp_t;

	// multi-cycle controller states
	typedef enum logic [3:0]
	{
		INIT, IF, IW, ID, EX, ST, LD, RDW, WB
	} cpuState_t;

	localparam int PERF_COUNT = 9;
	typedef logic [PERF_COUNT-1:0] perfEvent_t;

	// primary opcodes
	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_J       = 6'h02;
	localparam opcode_t OP_JAL     = 6'h03;
	localparam opcode_t OP_BEQ     = 6'h04;
	localparam opcode_t OP_BNE     = 6'h05;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_SLTI    = 6'h0a;
	localparam opcode_t OP_SLTIU   = 6'h0b;
	localparam opcode_t OP_ANDI    = 6'h0c;
	localparam opcode_t OP_ORI     = 6'h0d;
	localparam opcode_t OP_XORI    = 6'h0e;
	localparam opcode_t OP_LUI     = 6'h0f;
	localparam opcode_t OP_LW      = 6'h23;
	localparam opcode_t OP_SW      = 6'h2b;

	// function codes of the SPECIAL opcode
	localparam funct_t FN_SLL  = 6'h00;
	localparam funct_t FN_SRL  = 6'h02;
	localparam funct_t FN_SRA  = 6'h03;
	localparam funct_t FN_JR   = 6'h08;
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_XOR  = 6'h26;
	localparam funct_t FN_NOR  = 6'h27;
	localparam funct_t FN_SLT  = 6'h2a;
	localparam funct_t FN_SLTU = 6'h2b;

	localparam regAddr_t LINK_REG = 5'd31;
	localparam word_t    RESET_PC = 32'h0000_0000;
	localparam word_t    PC_STEP  = 32'd4;

	// counter indices
	localparam int PERF_CYCLE      = 0;
	localparam int PERF_INST       = 1;
	localparam int PERF_FETCH_WAIT = 2;
	localparam int PERF_INST_WAIT  = 3;
	localparam int PERF_STORE_REQ  = 4;
	localparam int PERF_LOAD_REQ   = 5;
	localparam int PERF_READ_WAIT  = 6;
	localparam int PERF_JUMP       = 7;
	localparam int PERF_BRANCH     = 8;

endpackage

//--- regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*;
(
	input  logic     clk,
	input  logic     wen,
	input  regAddr_t waddr,
	input  word_t    wdata,
	input  regAddr_t raddr1,
	input  regAddr_t raddr2,
	output word_t    rdata1,
	output word_t    rdata2
);

	word_t regs [32];

	// register 0 is never written
	always_ff @(posedge clk)
	begin
		if (wen && (waddr != '0))
			regs[waddr] <= wdata;
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	writeAddrKnown: assert property (@(posedge clk)
		wen |-> !$isunknown(waddr));

endmodule

//--- perfCounterBank.sv
`timescale 1ns/1ps

module perfCounterBank import cpuPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  perfEvent_t perfEvent,
	output word_t      perfCnt [PERF_COUNT]
);

	for (genvar i = 0; i < PERF_COUNT; i++)
	begin : genCounter
		word_t count;

		always_ff @(posedge clk)
		begin
			if (rst)
				count <= '0;
			else if (perfEvent[i])
				count <= count + 32'd1;
		end

		assign perfCnt[i] = count;
	end

endmodule

//--- instDecoder.sv
`timescale 1ns/1ps

module instDecoder import cpuPkg::*;
(
	input  logic        clk,
	input  logic        irWrite,
	input  word_t       instruction,
	output opcode_t     opcode,
	output regAddr_t    rs,
	output regAddr_t    rt,
	output regAddr_t    rd,
	output shamt_t      shamt,
	output logic [15:0] imm16,
	output logic [25:0] jumpTarget,
	output aluOp_t      aluOp,
	output logic        isNop,
	output logic        isRtype,
	output logic        isImmAlu,
	output logic        isLoad,
	output logic        isStore,
	output logic        isBranch,
	output logic        isBne,
	output logic        isJump,
	output logic        isJr,
	output logic        isLink
);

	word_t instReg;
	funct_t funct;
	logic isSpecial;

	always_ff @(posedge clk)
	begin
		if (irWrite)
			instReg <= instruction;
	end

	// field extraction
	assign opcode     = instReg[31:26];
	assign rs         = instReg[25:21];
	assign rt         = instReg[20:16];
	assign rd         = instReg[15:11];
	assign shamt      = instReg[10:6];
	assign funct      = instReg[5:0];
	assign imm16      = instReg[15:0];
	assign jumpTarget = instReg[25:0];

	// instruction classes
	assign isNop     = (instReg == '0);
	assign isSpecial = (opcode == OP_SPECIAL);
	assign isJr      = isSpecial && (funct == FN_JR);
	assign isRtype   = isSpecial && !isJr && !isNop;
	assign isImmAlu  = opcode inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
		OP_XORI, OP_LUI};
	assign isLoad    = (opcode == OP_LW);
	assign isStore   = (opcode == OP_SW);
	assign isBne     = (opcode == OP_BNE);
	assign isBranch  = (opcode == OP_BEQ) || isBne;
	assign isLink    = (opcode == OP_JAL);
	// j, jal and jr all redirect the PC unconditionally
	assign isJump    = (opcode == OP_J) || isLink || isJr;

	always_comb
	begin
		aluOp = ALU_ADD;
		if (isSpecial)
		begin
			case (funct)
				FN_SUBU: aluOp = ALU_SUB;
				FN_AND:  aluOp = ALU_AND;
				FN_OR:   aluOp = ALU_OR;
				FN_XOR:  aluOp = ALU_XOR;
				FN_NOR:  aluOp = ALU_NOR;
				FN_SLT:  aluOp = ALU_SLT;
				FN_SLTU: aluOp = ALU_SLTU;
				FN_SLL:  aluOp = ALU_SLL;
				FN_SRL:  aluOp = ALU_SRL;
				FN_SRA:  aluOp = ALU_SRA;
				default: aluOp = ALU_ADD;
			endcase
		end
		else
		begin
			case (opcode)
				OP_BEQ, OP_BNE: aluOp = ALU_SUB;
				OP_SLTI:        aluOp = ALU_SLT;
				OP_SLTIU:       aluOp = ALU_SLTU;
				OP_ANDI:        aluOp = ALU_AND;
				OP_ORI:         aluOp = ALU_OR;
				OP_XORI:        aluOp = ALU_XOR;
				OP_LUI:         aluOp = ALU_LUI;
				// addiu, lw and sw address arithmetic
				default:        aluOp = ALU_ADD;
			endcase
		end
	end

endmodule

//--- controlFsm.sv
`timescale 1ns/1ps

module controlFsm import cpuPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       instReqReady,
	input  logic       instValid,
	input  logic       memReqReady,
	input  logic       readDataValid,
	input  logic       isNop,
	input  logic       isRtype,
	input  logic       isImmAlu,
	input  logic       isLoad,
	input  logic       isStore,
	input  logic       isJump,
	input  logic       isLink,
	output logic       instReqValid,
	output logic       instReady,
	output logic       readDataReady,
	output logic       memRead,
	output logic       memWrite,
	output logic       irWrite,
	output logic       pcIncr,
	output logic       branchCalc,
	output logic       execute,
	output logic       loadCapture,
	output logic       writeBack,
	output perfEvent_t perfEvent
);

	cpuState_t state, nextState;
	logic inEx, isBranchClass;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= INIT;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			INIT: nextState = IF;
			IF:   if (instReqReady) nextState = IW;
			IW:   if (instValid) nextState = ID;
			ID:   nextState = isNop ? IF : EX;
			EX:
			begin
				if (isRtype || isImmAlu || isLink)
					nextState = WB;
				else if (isStore)
					nextState = ST;
				else if (isLoad)
					nextState = LD;
				else
					nextState = IF;
			end
			ST:   if (memReqReady) nextState = IF;
			LD:   if (memReqReady) nextState = RDW;
			RDW:  if (readDataValid) nextState = WB;
			WB:   nextState = IF;
			default: nextState = IF;
		endcase
	end

	// bus handshakes
	assign instReqValid  = (state == IF);
	assign instReady     = (state == IW);
	assign memWrite      = (state == ST);
	assign memRead       = (state == LD);
	assign readDataReady = (state == RDW);

	// phase strobes for decoder and datapath
	assign irWrite     = (state == IW) && instValid;
	assign pcIncr      = (state == IW) && instValid;
	assign branchCalc  = (state == ID);
	assign execute     = (state == EX);
	assign loadCapture = (state == RDW) && readDataValid;
	assign writeBack   = (state == WB);

	// whatever reaches EX without any other class is beq or bne
	assign inEx = (state == EX);
	assign isBranchClass = !(isRtype || isImmAlu || isLoad || isStore || isJump);

	always_comb
	begin
		perfEvent                  = '0;
		perfEvent[PERF_CYCLE]      = 1'b1;
		perfEvent[PERF_INST]       = (state == ID);
		perfEvent[PERF_FETCH_WAIT] = (state == IF);
		perfEvent[PERF_INST_WAIT]  = (state == IW);
		perfEvent[PERF_STORE_REQ]  = inEx && isStore;
		perfEvent[PERF_LOAD_REQ]   = inEx && isLoad;
		perfEvent[PERF_READ_WAIT]  = (state == RDW);
		perfEvent[PERF_JUMP]       = inEx && isJump;
		perfEvent[PERF_BRANCH]     = inEx && isBranchClass;
	end

	// requests stay up until the other side takes them
	instReqHeld: assert property (@(posedge clk) disable iff (rst)
		instReqValid && !instReqReady |=> instReqValid);

	memReqHeld: assert property (@(posedge clk) disable iff (rst)
		(memRead || memWrite) && !memReqReady |=> $stable({memRead, memWrite}));

endmodule

//--- dataPath.sv
`timescale 1ns/1ps

module dataPath import cpuPkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        pcIncr,
	input  logic        branchCalc,
	input  logic        execute,
	input  logic        loadCapture,
	input  logic        writeBack,
	input  logic        memRead,
	input  logic        memWrite,
	input  opcode_t     opcode,
	input  regAddr_t    rt,
	input  regAddr_t    rd,
	input  shamt_t      shamt,
	input  logic [15:0] imm16,
	input  logic [25:0] jumpTarget,
	input  aluOp_t      aluOp,
	input  logic        isRtype,
	input  logic        isImmAlu,
	input  logic        isLoad,
	input  logic        isStore,
	input  logic        isBranch,
	input  logic        isBne,
	input  logic        isJump,
	input  logic        isJr,
	input  logic        isLink,
	input  word_t       rdata1,
	input  word_t       rdata2,
	input  word_t       readData,
	output word_t       pc,
	output word_t       address,
	output word_t       writeData,
	output logic        wen,
	output regAddr_t    waddr,
	output word_t       wdata
);

	word_t opA, opB, result, loadData;
	word_t immExt, branchOffset, aluB, aluOut, jumpAddr;
	logic zeroExt, branchTaken;

	// logical immediates are zero-extended
	assign zeroExt = opcode inside {OP_ANDI, OP_ORI, OP_XORI};
	assign immExt  = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
	assign branchOffset = {{14{imm16[15]}}, imm16, 2'b00};
	assign aluB = (isImmAlu || isLoad || isStore) ? immExt : opB;

	always_comb
	begin
		case (aluOp)
			ALU_ADD:  aluOut = opA + aluB;
			ALU_SUB:  aluOut = opA - aluB;
			ALU_AND:  aluOut = opA & aluB;
			ALU_OR:   aluOut = opA | aluB;
			ALU_XOR:  aluOut = opA ^ aluB;
			ALU_NOR:  aluOut = ~(opA | aluB);
			ALU_SLT:  aluOut = {31'b0, $signed(opA) < $signed(aluB)};
			ALU_SLTU: aluOut = {31'b0, opA < aluB};
			ALU_SLL:  aluOut = opB << shamt;
			ALU_SRL:  aluOut = opB >> shamt;
			ALU_SRA:  aluOut = $signed(opB) >>> shamt;
			ALU_LUI:  aluOut = {imm16, 16'h0000};
			default:  aluOut = opA + aluB;
		endcase
	end

	// branches use the subtract result as the compare
	assign branchTaken = isBne ? (aluOut != '0) : (aluOut == '0);
	// pc already points past the jump here
	assign jumpAddr = isJr ? opA : {pc[31:28], jumpTarget, 2'b00};

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= RESET_PC;
		else if (pcIncr)
			pc <= pc + PC_STEP;
		else if (execute && isJump)
			pc <= jumpAddr;
		else if (execute && isBranch && branchTaken)
			pc <= result;
	end

	always_ff @(posedge clk)
	begin
		if (branchCalc)
		begin
			opA    <= rdata1;
			opB    <= rdata2;
			result <= pc + branchOffset;
		end
		else if (execute && !isBranch)
		begin
			// jal links to its own address plus 8
			result <= isLink ? pc + PC_STEP : aluOut;
		end
		if (loadCapture)
			loadData <= readData;
	end

	assign address   = (memRead || memWrite) ? result : pc;
	assign writeData = opB;

	// write-back selection
	assign wen   = writeBack;
	assign waddr = isLink ? LINK_REG : (isRtype ? rd : rt);
	assign wdata = isLoad ? loadData : result;

	pcAligned: assert property (@(posedge clk) disable iff (rst)
		pc[1:0] == 2'b00);

endmodule

//--- customCpu.sv
`timescale 1ns/1ps

module customCpu import cpuPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	output word_t    pc,
	output logic     instReqValid,
	input  logic     instReqReady,
	input  word_t    instruction,
	input  logic     instValid,
	output logic     instReady,
	output word_t    address,
	output logic     memRead,
	output logic     memWrite,
	output word_t    writeData,
	input  logic     memReqReady,
	input  word_t    readData,
	input  logic     readDataValid,
	output logic     readDataReady,
	output word_t    perfCnt [PERF_COUNT],
	output logic     retireWen,
	output regAddr_t retireAddr,
	output word_t    retireData,
	output word_t    retirePc
);

	// phase strobes
	logic irWrite, pcIncr, branchCalc, execute, loadCapture, writeBack;
	perfEvent_t perfEvent;

	// decoded instruction
	opcode_t opcode;
	regAddr_t rs, rt, rd;
	shamt_t shamt;
	logic [15:0] imm16;
	logic [25:0] jumpTarget;
	aluOp_t aluOp;
	logic isNop, isRtype, isImmAlu, isLoad, isStore;
	logic isBranch, isBne, isJump, isJr, isLink;

	// register file ports
	word_t rdata1, rdata2, wdata;
	regAddr_t waddr;
	logic wen;

	controlFsm controlFsm_i
	(
		.clk(clk), .rst(rst),
		.instReqReady(instReqReady), .instValid(instValid),
		.memReqReady(memReqReady), .readDataValid(readDataValid),
		.isNop(isNop), .isRtype(isRtype), .isImmAlu(isImmAlu), .isLoad(isLoad),
		.isStore(isStore), .isJump(isJump), .isLink(isLink),
		.instReqValid(instReqValid), .instReady(instReady), .readDataReady(readDataReady),
		.memRead(memRead), .memWrite(memWrite),
		.irWrite(irWrite), .pcIncr(pcIncr), .branchCalc(branchCalc), .execute(execute),
		.loadCapture(loadCapture), .writeBack(writeBack), .perfEvent(perfEvent)
	);

	instDecoder instDecoder_i
	(
		.clk(clk), .irWrite(irWrite), .instruction(instruction),
		.opcode(opcode), .rs(rs), .rt(rt), .rd(rd), .shamt(shamt),
		.imm16(imm16), .jumpTarget(jumpTarget), .aluOp(aluOp),
		.isNop(isNop), .isRtype(isRtype), .isImmAlu(isImmAlu), .isLoad(isLoad),
		.isStore(isStore), .isBranch(isBranch), .isBne(isBne), .isJump(isJump),
		.isJr(isJr), .isLink(isLink)
	);

	regFile regFile_i
	(
		.clk(clk), .wen(wen), .waddr(waddr), .wdata(wdata),
		.raddr1(rs), .raddr2(rt), .rdata1(rdata1), .rdata2(rdata2)
	);

	dataPath dataPath_i
	(
		.clk(clk), .rst(rst),
		.pcIncr(pcIncr), .branchCalc(branchCalc), .execute(execute),
		.loadCapture(loadCapture), .writeBack(writeBack),
		.memRead(memRead), .memWrite(memWrite),
		.opcode(opcode), .rt(rt), .rd(rd), .shamt(shamt), .imm16(imm16),
		.jumpTarget(jumpTarget), .aluOp(aluOp),
		.isRtype(isRtype), .isImmAlu(isImmAlu), .isLoad(isLoad), .isStore(isStore),
		.isBranch(isBranch), .isBne(isBne), .isJump(isJump), .isJr(isJr), .isLink(isLink),
		.rdata1(rdata1), .rdata2(rdata2), .readData(readData),
		.pc(pc), .address(address), .writeData(writeData),
		.wen(wen), .waddr(waddr), .wdata(wdata)
	);

	perfCounterBank perfCounterBank_i
	(
		.clk(clk), .rst(rst), .perfEvent(perfEvent), .perfCnt(perfCnt)
	);

	// retire trace mirrors the register-file write port
	assign retireWen  = wen;
	assign retireAddr = waddr;
	assign retireData = wdata;
	assign retirePc   = pc;

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock
(
	output logic clk,
	output logic rst,
	input  logic resetReq
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// three cycles of reset at start and again on every request
	initial
	begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		forever
		begin
			@(posedge clk);
			if (resetReq)
			begin
				rst <= 1'b1;
				repeat (3) @(posedge clk);
				rst <= 1'b0;
			end
		end
	end

endmodule

//--- tbCustomCpu.sv
`timescale 1ns/1ps

module tbCustomCpu import cpuPkg::*; ();

	localparam int PROG_LEN = 38;
	localparam int RETIRE_LEN = 26;
	localparam int WAIT_LIMIT = 400;
	localparam int STORE_IDX = 65;
	localparam word_t HALT_ADDR = 32'd152;
	localparam word_t STORE_ADDR = 32'h0000_0104;

	logic clk, rst;
	logic resetReq = 1'b0;
	logic instReqReady = 1'b0;
	logic instValid = 1'b0;
	logic memReqReady = 1'b0;
	logic readDataValid = 1'b0;
	word_t instruction = '0;
	word_t readData = '0;
	word_t pc, address, writeData, retireData, retirePc;
	logic instReqValid, instReady, memRead, memWrite, readDataReady, retireWen;
	regAddr_t retireAddr;
	word_t perfCnt [PERF_COUNT];

	integer seed = 25968;
	word_t mem [256];
	word_t progWords [PROG_LEN];
	regAddr_t expAddr [RETIRE_LEN];
	word_t expData [RETIRE_LEN];
	word_t expPc [RETIRE_LEN];
	word_t firstCnt [PERF_COUNT];
	word_t tallyInst, tallyJump, tallyBranch, tallyStore, tallyLoad;
	word_t tallyFetchWait, tallyInstWait, tallyReadWait;
	word_t storeSeen, storeAddr, storeData;
	word_t fetchAddr, dataAddr, dataWord;
	int instDelay, dataDelay;
	logic isWrite;
	int tests = 0;
	int errors = 0;
	bit runOk;

	tbClock clock_i (.clk(clk), .rst(rst), .resetReq(resetReq));

	customCpu dut_i
	(
		.clk(clk), .rst(rst), .pc(pc), .instReqValid(instReqValid),
		.instReqReady(instReqReady), .instruction(instruction), .instValid(instValid),
		.instReady(instReady), .address(address), .memRead(memRead), .memWrite(memWrite),
		.writeData(writeData), .memReqReady(memReqReady), .readData(readData),
		.readDataValid(readDataValid), .readDataReady(readDataReady), .perfCnt(perfCnt),
		.retireWen(retireWen), .retireAddr(retireAddr), .retireData(retireData),
		.retirePc(retirePc)
	);

	// instruction encoders
	function automatic word_t rOp(funct_t fn, int rs, int rt, int rd, int sh);
		return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic word_t iOp(opcode_t op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic word_t jOp(opcode_t op, int target);
		return {op, target[27:2]};
	endfunction

	function automatic int pickDelay();
		return int'($unsigned($random(seed)) % 32'd4);
	endfunction

	function automatic word_t fillWord(int i);
		return 32'hC0DE_0000 ^ word_t'(i) ^ (word_t'(i) << 20);
	endfunction

	task automatic loadTables();
		progWords = '{
			iOp(OP_ADDIU, 0, 1, 5), iOp(OP_ADDIU, 0, 2, -3),
			rOp(FN_ADDU, 1, 2, 3, 0), rOp(FN_SUBU, 1, 2, 4, 0),
			rOp(FN_AND, 1, 2, 5, 0), rOp(FN_OR, 1, 2, 6, 0),
			rOp(FN_XOR, 1, 2, 7, 0), rOp(FN_NOR, 1, 2, 8, 0),
			rOp(FN_SLT, 2, 1, 9, 0), rOp(FN_SLTU, 2, 1, 10, 0),
			rOp(FN_SLL, 0, 1, 11, 4), rOp(FN_SRL, 0, 2, 12, 28),
			rOp(FN_SRA, 0, 2, 13, 1), iOp(OP_LUI, 0, 14, 'h1234),
			iOp(OP_ORI, 14, 14, 'h5678), iOp(OP_ANDI, 2, 15, 'hff00),
			iOp(OP_XORI, 1, 16, 'hffff), iOp(OP_SLTI, 2, 17, -1),
			iOp(OP_SLTIU, 1, 18, -1), iOp(OP_ADDIU, 1, 0, 7),
			rOp(FN_ADDU, 0, 0, 19, 0), 32'h0000_0000,
			iOp(OP_ADDIU, 0, 20, 'h100), iOp(OP_SW, 20, 14, 4),
			iOp(OP_LW, 20, 21, 4), iOp(OP_BEQ, 1, 2, 5),
			iOp(OP_BNE, 1, 2, 1), iOp(OP_ADDIU, 0, 22, 1),
			iOp(OP_BEQ, 1, 1, 1), iOp(OP_ADDIU, 0, 22, 2),
			iOp(OP_BNE, 1, 1, 1), jOp(OP_JAL, 136),
			iOp(OP_ADDIU, 0, 22, 9), jOp(OP_J, 148),
			iOp(OP_ADDIU, 0, 23, 'h77), rOp(FN_JR, 31, 0, 0, 0),
			iOp(OP_ADDIU, 0, 22, 4), iOp(OP_ADDIU, 0, 24, 'h55)};
		// register writes in program order
		expAddr = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11,
			5'd12, 5'd13, 5'd14, 5'd14, 5'd15, 5'd16, 5'd17, 5'd18, 5'd0, 5'd19,
			5'd20, 5'd21, 5'd31, 5'd23, 5'd24};
		expData = '{32'h5, 32'hffff_fffd, 32'h2, 32'h8, 32'h5, 32'hffff_fffd,
			32'hffff_fff8, 32'h2, 32'h1, 32'h0, 32'h50, 32'hf, 32'hffff_fffe,
			32'h1234_0000, 32'h1234_5678, 32'hff00, 32'hfffa, 32'h1, 32'h1, 32'hc,
			32'h0, 32'h100, 32'h1234_5678, 32'd132, 32'h77, 32'h55};
		// pc has already stepped past the writer, jal shows its target
		expPc = '{32'd4, 32'd8, 32'd12, 32'd16, 32'd20, 32'd24, 32'd28, 32'd32, 32'd36,
			32'd40, 32'd44, 32'd48, 32'd52, 32'd56, 32'd60, 32'd64, 32'd68, 32'd72,
			32'd76, 32'd80, 32'd84, 32'd92, 32'd100, 32'd136, 32'd140, 32'd152};
	endtask

	task automatic checkAddr(string name, regAddr_t expV, regAddr_t actV);
		tests++;
		if (expV !== actV)
		begin
			errors++;
			$display("Error %s: expected %0d, actual %0d", name, expV, actV);
		end
		else
			$display("pass %s", name);
	endtask

	task automatic checkWord(string name, word_t expV, word_t actV);
		tests++;
		if (expV !== actV)
		begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expV, actV);
		end
		else
			$display("pass %s", name);
	endtask

	task automatic checkAtLeast(string name, word_t minV, word_t actV);
		tests++;
		if (actV < minV)
		begin
			errors++;
			$display("Error %s: expected at least %0d, actual %0d", name, minV, actV);
		end
		else
			$display("pass %s", name);
	endtask

	task automatic reportFailure(string msg);
		tests++;
		errors++;
		$display("%s", msg);
	endtask

	// tally of the executed path, one call per accepted fetch
	task automatic classify(word_t w);
		tallyInst = tallyInst + 32'd1;
		if (w[31:26] == OP_J || w[31:26] == OP_JAL || (w[31:26] == OP_SPECIAL && w[5:0] == FN_JR))
			tallyJump = tallyJump + 32'd1;
		if (w[31:26] == OP_BEQ || w[31:26] == OP_BNE)
			tallyBranch = tallyBranch + 32'd1;
		if (w[31:26] == OP_SW)
			tallyStore = tallyStore + 32'd1;
		if (w[31:26] == OP_LW)
			tallyLoad = tallyLoad + 32'd1;
	endtask

	// instruction side of the memory model, silent at the halt address
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (instReqValid && pc != HALT_ADDR && !rst)
			begin
				fetchAddr = pc;
				// IF lasts the delay plus the ready cycle plus the first one
				instDelay = pickDelay();
				tallyFetchWait = tallyFetchWait + word_t'(instDelay + 2);
				repeat (instDelay) @(posedge clk);
				@(posedge clk);
				instReqReady <= 1'b1;
				@(posedge clk);
				instReqReady <= 1'b0;
				instDelay = pickDelay();
				tallyInstWait = tallyInstWait + word_t'(instDelay + 1);
				repeat (instDelay) @(posedge clk);
				instruction <= mem[fetchAddr[9:2]];
				instValid <= 1'b1;
				@(negedge clk);
				if (!instReady)
					reportFailure("instReady was low while the instruction was presented");
				@(posedge clk);
				instValid <= 1'b0;
				classify(mem[fetchAddr[9:2]]);
			end
		end
	end

	// data side of the memory model
	initial
	begin
		forever
		begin
			@(negedge clk);
			if ((memRead || memWrite) && !rst)
			begin
				dataAddr = address;
				dataWord = writeData;
				isWrite = memWrite;
				repeat (pickDelay()) @(posedge clk);
				@(posedge clk);
				memReqReady <= 1'b1;
				@(posedge clk);
				memReqReady <= 1'b0;
				if (isWrite)
				begin
					mem[dataAddr[9:2]] = dataWord;
					storeSeen = storeSeen + 32'd1;
					storeAddr = dataAddr;
					storeData = dataWord;
				end
				else
				begin
					dataDelay = pickDelay();
					tallyReadWait = tallyReadWait + word_t'(dataDelay + 1);
					repeat (dataDelay) @(posedge clk);
					readData <= mem[dataAddr[9:2]];
					readDataValid <= 1'b1;
					@(negedge clk);
					if (!readDataReady)
						reportFailure("readDataReady was low while read data was presented");
					@(posedge clk);
					readDataValid <= 1'b0;
				end
			end
		end
	end

	task automatic runProgram(int runIdx, output bit ok);
		int i;
		int n;
		logic sawHigh;
		string tag;
		tag = $sformatf("run%0d", runIdx);
		tallyInst = '0;
		tallyJump = '0;
		tallyBranch = '0;
		tallyStore = '0;
		tallyLoad = '0;
		tallyFetchWait = '0;
		tallyInstWait = '0;
		tallyReadWait = '0;
		storeSeen = '0;
		storeAddr = '0;
		storeData = '0;
		mem[STORE_IDX] = fillWord(STORE_IDX);
		if (runIdx > 0)
		begin
			@(posedge clk);
			resetReq <= 1'b1;
			@(posedge clk);
			resetReq <= 1'b0;
		end
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++)
		begin
			@(negedge clk);
			ok = rst;
		end
		if (!ok)
		begin
			reportFailure({tag, " reset was never applied"});
			return;
		end
		sawHigh = 1'b0;
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++)
		begin
			@(negedge clk);
			sawHigh = sawHigh | instReqValid | memRead | memWrite | retireWen;
			ok = !rst;
		end
		if (!ok)
		begin
			reportFailure({tag, " reset was never released"});
			return;
		end
		checkWord({tag, " outputs low in reset"}, 32'd0, {31'b0, sawHigh});
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++)
		begin
			@(negedge clk);
			ok = instReqValid;
		end
		if (!ok)
		begin
			reportFailure({tag, " no instruction fetch after reset"});
			return;
		end
		checkWord({tag, " first fetch address"}, RESET_PC, pc);
		for (i = 0; i < RETIRE_LEN; i++)
		begin
			ok = 1'b0;
			for (n = 0; n < WAIT_LIMIT && !ok; n++)
			begin
				@(negedge clk);
				ok = retireWen;
			end
			if (!ok)
			begin
				reportFailure($sformatf("%s register write %0d never happened", tag, i));
				return;
			end
			checkAddr($sformatf("%s retire %0d addr", tag, i), expAddr[i], retireAddr);
			checkWord($sformatf("%s retire %0d data", tag, i), expData[i], retireData);
			checkWord($sformatf("%s retire %0d pc", tag, i), expPc[i], retirePc);
		end
		ok = 1'b0;
		for (n = 0; n < WAIT_LIMIT && !ok; n++)
		begin
			@(negedge clk);
			ok = instReqValid && (pc == HALT_ADDR);
		end
		if (!ok)
		begin
			reportFailure({tag, " program did not reach the halt address"});
			return;
		end
		repeat (2) @(negedge clk);
		checkWord({tag, " store count"}, 32'd1, storeSeen);
		checkWord({tag, " store address"}, STORE_ADDR, storeAddr);
		checkWord({tag, " store data"}, 32'h1234_5678, storeData);
		checkWord({tag, " inst counter"}, tallyInst, perfCnt[PERF_INST]);
		checkWord({tag, " jump counter"}, tallyJump, perfCnt[PERF_JUMP]);
		checkWord({tag, " branch counter"}, tallyBranch, perfCnt[PERF_BRANCH]);
		checkWord({tag, " store counter"}, tallyStore, perfCnt[PERF_STORE_REQ]);
		checkWord({tag, " load counter"}, tallyLoad, perfCnt[PERF_LOAD_REQ]);
		// the unanswered fetch at the halt address has waited two cycles
		checkWord({tag, " fetch wait counter"}, tallyFetchWait + 32'd2,
			perfCnt[PERF_FETCH_WAIT]);
		checkWord({tag, " inst wait counter"}, tallyInstWait, perfCnt[PERF_INST_WAIT]);
		checkWord({tag, " read wait counter"}, tallyReadWait, perfCnt[PERF_READ_WAIT]);
		checkAtLeast({tag, " cycle counter"}, tallyInst * 32'd5, perfCnt[PERF_CYCLE]);
		if (runIdx > 0)
		begin
			checkWord({tag, " inst count repeat"}, firstCnt[PERF_INST], perfCnt[PERF_INST]);
			checkWord({tag, " jump count repeat"}, firstCnt[PERF_JUMP], perfCnt[PERF_JUMP]);
			checkWord({tag, " branch count repeat"}, firstCnt[PERF_BRANCH],
				perfCnt[PERF_BRANCH]);
			checkWord({tag, " store count repeat"}, firstCnt[PERF_STORE_REQ],
				perfCnt[PERF_STORE_REQ]);
			checkWord({tag, " load count repeat"}, firstCnt[PERF_LOAD_REQ],
				perfCnt[PERF_LOAD_REQ]);
		end
		else
			firstCnt = perfCnt;
	endtask

	initial
	begin
		loadTables();
		for (int i = 0; i < 256; i++)
			mem[i] = fillWord(i);
		for (int i = 0; i < PROG_LEN; i++)
			mem[i] = progWords[i];
		runProgram(0, runOk);
		// second pass sees new random delays
		if (runOk)
			runProgram(1, runOk);
		$display("tests: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- list.f
cpuPkg.sv
regFile.sv
perfCounterBank.sv
instDecoder.sv
controlFsm.sv
dataPath.sv
customCpu.sv
tbClock.sv
tbCustomCpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbCustomCpu -f list.f -o simCustomCpu
./obj_dir/simCustomCpu | tee sim.log
if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
	echo "simulation did not complete"
	exit 1
fi
